// File: tb.f
+incdir+include
verilog/cache_pkg.sv
verilog/cache_tags.sv
verilog/cache_line_data.sv
verilog/line_transfer.sv
verilog/cache_control.sv
verilog/data_cache.sv
tb/burst_ram_model.sv
tb/data_cache_properties.sv
tb/tb_data_cache.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the data cache testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
  -f tb.f --top-module tb_data_cache -o sim_data_cache

# the simulator exits non-zero on a fatal check, the log still decides
./obj_dir/sim_data_cache 2>&1 | tee sim.log || true

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  echo "no pass line found in sim.log"
  exit 1
fi

// File: tb/tb_data_cache.sv
/*
  random and directed requests against a reference byte memory of the low 2 KB
  every read answer, ram command address and write-back beat is compared
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module tb_data_cache import cache_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RANDOM_REQS = 2000;
  localparam int DIRECTED_REQS = 6;
  localparam int MEM_BYTES = 2048;
  localparam int LINES = 2 ** `CACHE_LINE_IX_W;
  localparam logic [31:0] SEED = 32'h0e946600;
  // 200 cycles per request plus margin for reset and drain
  localparam time WATCHDOG_NS = time'(RANDOM_REQS + DIRECTED_REQS + 10) * 200 * CLK_PERIOD;

  logic clk;
  logic rst;
  logic req_valid;
  logic req_ready;
  cache_addr_u req_addr;
  byte_en_t req_byte_en;
  cache_word_t req_wdata;
  logic rsp_valid;
  cache_word_t rsp_data;
  logic br_cmd;
  logic br_cmd_en;
  ram_addr_t br_addr;
  ram_word_t br_wr_data;
  logic [`CACHE_RAM_WORD_W/8-1:0] br_data_mask;
  ram_word_t br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;

  logic [7:0] ref_mem [MEM_BYTES];
  cache_word_t expected_q [$];
  logic [31:0] rnd;
  int wb_count;
  int fetch_count;
  int wb_left;
  ram_addr_t wb_addr;

  // shadow directory of the cache, predicts every ram burst address
  logic model_valid [LINES];
  logic model_dirty [LINES];
  tag_t model_tag [LINES];
  ram_addr_t wb_q [$];
  ram_addr_t fetch_q [$];

  data_cache data_cache_inst (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_addr(req_addr),
    .req_byte_en(req_byte_en),
    .req_wdata(req_wdata),
    .rsp_valid(rsp_valid),
    .rsp_data(rsp_data),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_data_mask(br_data_mask),
    .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .br_busy(br_busy)
  );

  burst_ram_model #(.SEED(SEED)) ram_inst (
    .clk(clk),
    .rst(rst),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_data_mask(br_data_mask),
    .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .br_busy(br_busy)
  );

  // preload rule of the ram for one beat address
  function automatic ram_word_t preload_beat(ram_addr_t a);
    return {8'h9e, ~a, a, 8'h17, a ^ 8'h3c, 8'he1, a + 8'h55, ~a ^ 8'ha0};
  endfunction

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // little endian word out of the reference bytes
  function automatic cache_word_t ref_word(int a);
    return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
  endfunction

  function automatic ram_word_t ref_beat(ram_addr_t a);
    ram_word_t w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = ref_mem[int'(a) * 8 + b];
    end
    return w;
  endfunction

  // first ram beat of a line, lines are aligned to whole bursts
  function automatic ram_addr_t line_beat(tag_t t, line_ix_t l);
    logic [31:0] base;
    base = {t, l, {(`CACHE_WORD_IX_W + `CACHE_BYTE_OFS_W){1'b0}}};
    return ram_addr_t'(base / (`CACHE_RAM_WORD_W / 8));
  endfunction

  task automatic check_word(string name, cache_word_t got, cache_word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_ram_word(string name, ram_word_t got, ram_word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_ram_addr(string name, ram_addr_t got, ram_addr_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_mask(string name, logic [`CACHE_RAM_WORD_W/8-1:0] got,
                            logic [`CACHE_RAM_WORD_W/8-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // direct mapped lookup in the shadow directory for an accepted request
  task automatic update_directory(cache_addr_u a, logic is_write);
    line_ix_t l;
    l = a.f.line_ix;
    if (!model_valid[l] || model_tag[l] != a.f.tag) begin
      // a modified victim goes back to the ram before the fetch
      if (model_valid[l] && model_dirty[l]) begin
        wb_q.push_back(line_beat(model_tag[l], l));
      end
      fetch_q.push_back(line_beat(a.f.tag, l));
      model_valid[l] = 1'b1;
      model_tag[l] = a.f.tag;
      model_dirty[l] = 1'b0;
    end
    if (is_write) begin
      model_dirty[l] = 1'b1;
    end
  endtask

  // hold the request until the cache takes it
  task automatic send_request(logic [31:0] addr, byte_en_t be, cache_word_t data);
    req_valid <= 1'b1;
    req_addr.raw <= addr;
    req_byte_en <= be;
    req_wdata <= data;
    @(posedge clk);
    while (!req_ready) begin
      @(posedge clk);
    end
  endtask

  // idle the bus until the cache is idle, then one more edge for the last answer
  task automatic drain_requests();
    req_valid <= 1'b0;
    @(posedge clk);
    while (!req_ready) begin
      @(posedge clk);
    end
    @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the cache stopped accepting or answering requests");
    $display("Simulation failed");
    $fatal(1);
  end

  // answers are checked before the request taken on this edge
  always @(posedge clk) begin
    if (!rst) begin
      if (rsp_valid) begin
        if (expected_q.size() == 0) begin
          $display("response at %0t ns with no read outstanding", $time);
          $display("Simulation failed");
          $fatal(1);
        end else begin
          check_word("rsp_data", rsp_data, expected_q.pop_front());
        end
      end
      if (req_valid && req_ready) begin
        update_directory(req_addr, req_byte_en != '0);
        if (req_byte_en == '0) begin
          expected_q.push_back(ref_word(int'(req_addr.raw)));
        end else begin
          for (int b = 0; b < 4; b++) begin
            if (req_byte_en[b]) begin
              ref_mem[int'(req_addr.raw) + b] = req_wdata[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  // ram commands against the shadow directory, write-back beats against the reference
  always @(posedge clk) begin
    if (rst) begin
      wb_left = 0;
    end else if (br_cmd_en && br_cmd) begin
      if (wb_q.size() == 0) begin
        $display("write-back at %0t ns with no dirty line being replaced", $time);
        $display("Simulation failed");
        $fatal(1);
      end else begin
        wb_addr = wb_q.pop_front();
        wb_count = wb_count + 1;
        check_ram_addr("br_addr", br_addr, wb_addr);
        check_mask("br_data_mask", br_data_mask, '1);
        check_ram_word("br_wr_data", br_wr_data, ref_beat(wb_addr));
        wb_left = `CACHE_BURST_LEN - 1;
      end
    end else if (wb_left > 0) begin
      wb_addr = wb_addr + 1'b1;
      check_mask("br_data_mask", br_data_mask, '1);
      check_ram_word("br_wr_data", br_wr_data, ref_beat(wb_addr));
      wb_left = wb_left - 1;
    end
    if (!rst && br_cmd_en && !br_cmd) begin
      if (fetch_q.size() == 0) begin
        $display("fetch at %0t ns with no miss outstanding", $time);
        $display("Simulation failed");
        $fatal(1);
      end else begin
        fetch_count = fetch_count + 1;
        check_ram_addr("br_addr", br_addr, fetch_q.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] addr;
    byte_en_t be;
    ram_word_t pre;
    rst = 1'b1;
    req_valid = 1'b0;
    req_addr = '0;
    req_byte_en = '0;
    req_wdata = '0;
    wb_count = 0;
    fetch_count = 0;
    rnd = SEED;
    for (int l = 0; l < LINES; l++) begin
      model_valid[l] = 1'b0;
      model_dirty[l] = 1'b0;
    end
    for (int a = 0; a < MEM_BYTES / 8; a++) begin
      pre = preload_beat(ram_addr_t'(a));
      for (int b = 0; b < 8; b++) begin
        ref_mem[a * 8 + b] = pre[b*8 +: 8];
      end
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // cold miss followed by a hit on the same line
    send_request(32'h40, 4'b0000, '0);
    send_request(32'h40, 4'b0000, '0);
    // masked write and read back
    send_request(32'h44, 4'b0101, 32'hdeadbeef);
    send_request(32'h44, 4'b0000, '0);
    // same line index with another tag forces write-back of the dirty line
    send_request(32'hc0, 4'b0000, '0);
    send_request(32'h44, 4'b0000, '0);
    drain_requests();
    if (fetch_count == 0 || wb_count == 0) begin
      $display("directed accesses caused no fetch or no write-back");
      $display("Simulation failed");
      $fatal(1);
    end

    // mixed random traffic with half of it reads
    for (int i = 0; i < RANDOM_REQS; i++) begin
      rnd = lcg_step(rnd);
      addr = {21'b0, rnd[26:18], 2'b00};
      be = rnd[31] ? byte_en_t'(rnd[3:0] | 4'b0001 << rnd[5:4]) : '0;
      rnd = lcg_step(rnd);
      send_request(addr, be, rnd);
    end
    drain_requests();

    if (expected_q.size() != 0 || wb_q.size() != 0 || fetch_q.size() != 0) begin
      $display("reads or ram bursts still outstanding at the end of the run");
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// File: tb/data_cache_properties.sv
/*
  protocol assertions bound into data_cache
*/
`timescale 1ns/1ns

module data_cache_properties (
  input logic clk,
  input logic rst,
  input logic req_ready,
  input logic rsp_valid,
  input logic br_cmd_en
);

  // a read miss answers on a single cycle while req_ready is low
  assert property (@(posedge clk) disable iff (rst)
    (rsp_valid && !req_ready) |=> !rsp_valid)
    else $error("read miss answered on two cycles in a row");

  // a ram command is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en high on two cycles in a row");

  // cache is idle right after reset
  assert property (@(posedge clk)
    ($past(rst) && !rst) |-> req_ready)
    else $error("req_ready low after reset");

endmodule

bind data_cache data_cache_properties data_cache_properties_inst (
  .clk(clk),
  .rst(rst),
  .req_ready(req_ready),
  .rsp_valid(rsp_valid),
  .br_cmd_en(br_cmd_en)
);

// File: tb/burst_ram_model.sv
/*
  behavioural burst ram, 256 beats, preloaded with a pattern of the beat address
  read data follows a command after 2 to 5 cycles; busy is high during a burst
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module burst_ram_model import cache_pkg::*; #(
  parameter logic [31:0] SEED = 32'h1
) (
  input  logic clk,
  input  logic rst,
  input  logic br_cmd,
  input  logic br_cmd_en,
  input  ram_addr_t br_addr,
  input  ram_word_t br_wr_data,
  input  logic [`CACHE_RAM_WORD_W/8-1:0] br_data_mask,
  output ram_word_t br_rd_data,
  output logic br_rd_data_valid,
  output logic br_busy
);

  localparam int DEPTH = 2 ** `CACHE_RAM_ADDR_W;
  localparam int BYTES = `CACHE_RAM_WORD_W / 8;

  ram_word_t mem [DEPTH];
  logic [31:0] rnd;
  int wr_left;
  ram_addr_t wr_addr;
  int rd_left;
  int rd_wait;
  ram_addr_t rd_addr;

  // every byte depends on the whole beat address
  function automatic ram_word_t pattern_beat(ram_addr_t a);
    return {8'h9e, ~a, a, 8'h17, a ^ 8'h3c, 8'he1, a + 8'h55, ~a ^ 8'ha0};
  endfunction

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // byte masked beat write
  task automatic write_beat(ram_addr_t a, ram_word_t d, logic [BYTES-1:0] m);
    for (int b = 0; b < BYTES; b++) begin
      if (m[b]) begin
        mem[a][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = pattern_beat(ram_addr_t'(a));
    end
    rnd = SEED;
    br_busy = 1'b0;
    br_rd_data_valid = 1'b0;
    br_rd_data = '0;
  end

  always @(posedge clk) begin
    if (rst) begin
      br_busy <= 1'b0;
      br_rd_data_valid <= 1'b0;
      br_rd_data <= '0;
      wr_left = 0;
      rd_left = 0;
      rd_wait = 0;
    end else begin
      rnd = lcg_step(rnd);
      br_rd_data_valid <= 1'b0;
      // beat 0 is written with the command and three more follow
      if (br_cmd_en && br_cmd) begin
        write_beat(br_addr, br_wr_data, br_data_mask);
        wr_addr = br_addr + 1'b1;
        wr_left = `CACHE_BURST_LEN - 1;
      end else if (wr_left > 0) begin
        write_beat(wr_addr, br_wr_data, br_data_mask);
        wr_addr = wr_addr + 1'b1;
        wr_left = wr_left - 1;
      end
      // read beats back to back after a random wait
      if (rd_left > 0) begin
        if (rd_wait > 0) begin
          rd_wait = rd_wait - 1;
        end else begin
          br_rd_data <= mem[rd_addr];
          br_rd_data_valid <= 1'b1;
          rd_addr = rd_addr + 1'b1;
          rd_left = rd_left - 1;
        end
      end
      if (br_cmd_en && !br_cmd) begin
        rd_addr = br_addr;
        rd_left = `CACHE_BURST_LEN;
        rd_wait = int'(rnd[17:16]);
      end
      // busy during bursts plus random stalls
      br_busy <= (wr_left != 0) || (rd_left != 0) || (rnd[25:23] == 3'd0);
    end
  end

endmodule

// File: verilog/data_cache.sv
/*
  direct mapped write-back data cache in front of a burst ram
  requests must be word aligned; only the low 2 KB map onto distinct ram words
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module data_cache import cache_pkg::*; (
  input  logic clk,
  input  logic rst,
  // request side, zero byte enable reads
  input  logic req_valid,
  output logic req_ready,
  input  cache_addr_u req_addr,
  input  byte_en_t req_byte_en,
  input  cache_word_t req_wdata,
  // read response, no back-pressure
  output logic rsp_valid,
  output cache_word_t rsp_data,
  // burst ram
  output logic br_cmd,
  output logic br_cmd_en,
  output ram_addr_t br_addr,
  output ram_word_t br_wr_data,
  output logic [`CACHE_RAM_WORD_W/8-1:0] br_data_mask,
  input  ram_word_t br_rd_data,
  input  logic br_rd_data_valid,
  input  logic br_busy
);

  cache_addr_u lookup_addr;
  logic hit;
  logic dirty;
  tag_t victim_tag;
  logic set_line;
  logic set_dirty;
  logic write_word;
  byte_en_t byte_en;
  cache_word_t wdata;
  cache_word_t word_out;
  beat_ix_t beat_ix;
  logic fill_en;
  ram_word_t fill_beat;
  ram_word_t drain_beat;
  logic start_writeback;
  logic start_fetch;
  ram_addr_t ram_line_addr;
  logic transfer_done;

  cache_control cache_control_inst (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .req_byte_en(req_byte_en),
    .req_wdata(req_wdata),
    .hit(hit),
    .dirty(dirty),
    .victim_tag(victim_tag),
    .word_out(word_out),
    .fill_en(fill_en),
    .beat_ix(beat_ix),
    .fill_beat(fill_beat),
    .transfer_done(transfer_done),
    .req_ready(req_ready),
    .rsp_valid(rsp_valid),
    .rsp_data(rsp_data),
    .lookup_addr(lookup_addr),
    .set_line(set_line),
    .set_dirty(set_dirty),
    .write_word(write_word),
    .byte_en(byte_en),
    .wdata(wdata),
    .start_writeback(start_writeback),
    .start_fetch(start_fetch),
    .ram_line_addr(ram_line_addr)
  );

  cache_tags cache_tags_inst (
    .clk(clk),
    .rst(rst),
    .lookup_addr(lookup_addr),
    .set_line(set_line),
    .set_dirty(set_dirty),
    .hit(hit),
    .dirty(dirty),
    .victim_tag(victim_tag)
  );

  // line and word always come from the registered request
  cache_line_data cache_line_data_inst (
    .clk(clk),
    .line_ix(lookup_addr.f.line_ix),
    .word_ix(lookup_addr.f.word_ix),
    .byte_en(byte_en),
    .wdata(wdata),
    .write_word(write_word),
    .beat_ix(beat_ix),
    .fill_beat(fill_beat),
    .fill_en(fill_en),
    .word_out(word_out),
    .drain_beat(drain_beat)
  );

  line_transfer line_transfer_inst (
    .clk(clk),
    .rst(rst),
    .start_writeback(start_writeback),
    .start_fetch(start_fetch),
    .ram_line_addr(ram_line_addr),
    .drain_beat(drain_beat),
    .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .br_busy(br_busy),
    .beat_ix(beat_ix),
    .fill_en(fill_en),
    .fill_beat(fill_beat),
    .transfer_done(transfer_done),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_data_mask(br_data_mask)
  );

endmodule

// File: verilog/cache_control.sv
/*
  request FSM: lookup, optional write-back, fetch, merge
  a hit frees req_ready in the lookup cycle; a read miss answers on its fill beat
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_control import cache_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  cache_addr_u req_addr,
  input  byte_en_t req_byte_en,
  input  cache_word_t req_wdata,
  input  logic hit,
  input  logic dirty,
  input  tag_t victim_tag,
  input  cache_word_t word_out,
  input  logic fill_en,
  input  beat_ix_t beat_ix,
  input  ram_word_t fill_beat,
  input  logic transfer_done,
  output logic req_ready,
  output logic rsp_valid,
  output cache_word_t rsp_data,
  output cache_addr_u lookup_addr,
  output logic set_line,
  output logic set_dirty,
  output logic write_word,
  output byte_en_t byte_en,
  output cache_word_t wdata,
  output logic start_writeback,
  output logic start_fetch,
  output ram_addr_t ram_line_addr
);

  // one-hot state bit positions
  localparam int S_IDLE = 0;
  localparam int S_LOOKUP = 1;
  localparam int S_WRITEBACK = 2;
  localparam int S_FETCH = 3;
  localparam int S_MERGE = 4;

  localparam int WPB = `CACHE_WORDS_PER_BEAT;
  localparam int WORD_W = $bits(cache_word_t);
  // byte address to ram beat address
  localparam int BEAT_SHIFT = `CACHE_BYTE_OFS_W + $clog2(WPB);

  logic [4:0] state;
  logic [4:0] state_next;
  logic is_read;
  logic lookup_hit;
  logic early_rsp;
  beat_ix_t want_beat;
  cache_word_t fill_word;
  cache_addr_u victim_addr;
  cache_addr_u fill_addr;

  assign is_read = (byte_en == '0);
  assign lookup_hit = state[S_LOOKUP] && hit;

  // a hit finishes in the lookup cycle, so the next request can follow
  assign req_ready = state[S_IDLE] || lookup_hit;

  assign write_word = (lookup_hit && !is_read) || state[S_MERGE];
  assign set_dirty = write_word;

  // dirty victims go out before the new line comes in
  assign start_writeback = state[S_LOOKUP] && !hit && dirty;
  assign start_fetch = (state[S_LOOKUP] && !hit && !dirty)
                    || (state[S_WRITEBACK] && transfer_done);
  // tag flips to the new line when its fetch starts
  assign set_line = start_fetch;

  // line base addresses, word and byte fields cleared
  always_comb begin
    victim_addr = lookup_addr;
    victim_addr.f.tag = victim_tag;
    victim_addr.f.word_ix = '0;
    victim_addr.f.byte_ofs = '0;
    fill_addr = lookup_addr;
    fill_addr.f.word_ix = '0;
    fill_addr.f.byte_ofs = '0;
  end

  assign ram_line_addr = start_writeback ? victim_addr.raw[BEAT_SHIFT +: $bits(ram_addr_t)]
                                         : fill_addr.raw[BEAT_SHIFT +: $bits(ram_addr_t)];

  // which beat carries the wanted word, and where in it
  assign want_beat = beat_ix_t'(lookup_addr.f.word_ix >> $clog2(WPB));

  always_comb begin
    fill_word = fill_beat[WORD_W-1:0];
    for (int w = 0; w < WPB; w++) begin
      if ((int'(lookup_addr.f.word_ix) % WPB) == w) begin
        fill_word = fill_beat[w*WORD_W +: WORD_W];
      end
    end
  end

  // read miss answers as soon as its beat arrives
  assign early_rsp = state[S_FETCH] && fill_en && is_read && (beat_ix == want_beat);

  assign rsp_valid = (lookup_hit && is_read) || early_rsp;
  assign rsp_data = early_rsp ? fill_word : word_out;

  always_comb begin
    state_next = state;
    unique case (1'b1)
      state[S_IDLE]: begin
        if (req_valid) begin
          state_next = 5'b1 << S_LOOKUP;
        end
      end
      state[S_LOOKUP]: begin
        if (hit) begin
          state_next = req_valid ? (5'b1 << S_LOOKUP) : (5'b1 << S_IDLE);
        end else if (dirty) begin
          state_next = 5'b1 << S_WRITEBACK;
        end else begin
          state_next = 5'b1 << S_FETCH;
        end
      end
      state[S_WRITEBACK]: begin
        if (transfer_done) begin
          state_next = 5'b1 << S_FETCH;
        end
      end
      state[S_FETCH]: begin
        // writes merge only after the whole line is in
        if (transfer_done) begin
          state_next = is_read ? (5'b1 << S_IDLE) : (5'b1 << S_MERGE);
        end
      end
      default: begin
        state_next = 5'b1 << S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= 5'b1 << S_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // request payload, captured on the handshake
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      lookup_addr <= req_addr;
      byte_en <= req_byte_en;
      wdata <= req_wdata;
    end
  end

endmodule

// File: verilog/line_transfer.sv
/*
  burst sequencer: waits for br_busy low, then moves one line in four beats
  write beat 0 rides with the command; transfer_done is a one-cycle pulse
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module line_transfer import cache_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start_writeback,
  input  logic start_fetch,
  input  ram_addr_t ram_line_addr,
  input  ram_word_t drain_beat,
  input  ram_word_t br_rd_data,
  input  logic br_rd_data_valid,
  input  logic br_busy,
  output beat_ix_t beat_ix,
  output logic fill_en,
  output ram_word_t fill_beat,
  output logic transfer_done,
  output logic br_cmd,
  output logic br_cmd_en,
  output ram_addr_t br_addr,
  output ram_word_t br_wr_data,
  output logic [`CACHE_RAM_WORD_W/8-1:0] br_data_mask
);

  localparam logic [1:0] XF_IDLE = 2'd0;
  localparam logic [1:0] XF_CMD = 2'd1;
  localparam logic [1:0] XF_WRITE = 2'd2;
  localparam logic [1:0] XF_READ = 2'd3;
  localparam beat_ix_t LAST_BEAT = beat_ix_t'(`CACHE_BURST_LEN - 1);

  logic [1:0] state;
  logic is_write;
  beat_ix_t beat;
  ram_addr_t line_addr;

  // command only goes out once the ram is free
  assign br_cmd_en = (state == XF_CMD) && !br_busy;
  assign br_cmd = is_write;
  assign br_addr = line_addr;
  // beat 0 during the command cycle, then beats 1..3
  assign br_wr_data = drain_beat;
  assign br_data_mask = is_write ? '1 : '0;

  assign beat_ix = beat;
  assign fill_en = (state == XF_READ) && br_rd_data_valid;
  assign fill_beat = br_rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= XF_IDLE;
      is_write <= 1'b0;
      beat <= '0;
      transfer_done <= 1'b0;
    end else begin
      transfer_done <= 1'b0;
      case (state)
        XF_IDLE: begin
          if (start_writeback || start_fetch) begin
            is_write <= start_writeback;
            beat <= '0;
            state <= XF_CMD;
          end
        end
        XF_CMD: begin
          if (!br_busy) begin
            // write beat 0 already left with the command
            beat <= is_write ? beat_ix_t'(1) : '0;
            state <= is_write ? XF_WRITE : XF_READ;
          end
        end
        XF_WRITE: begin
          beat <= beat + 1'b1;
          if (beat == LAST_BEAT) begin
            transfer_done <= 1'b1;
            state <= XF_IDLE;
          end
        end
        default: begin
          // read beats come back to back once they start
          if (br_rd_data_valid) begin
            beat <= beat + 1'b1;
            if (beat == LAST_BEAT) begin
              transfer_done <= 1'b1;
              state <= XF_IDLE;
            end
          end
        end
      endcase
    end
  end

  // line address is latched at start and held for the whole burst
  always_ff @(posedge clk) begin
    if (state == XF_IDLE && (start_writeback || start_fetch)) begin
      line_addr <= ram_line_addr;
    end
  end

endmodule

// File: verilog/cache_line_data.sv
/*
  line storage with byte merge, beat fill and beat drain
  word w of a beat sits at bits w*word_w and up; no reset on data
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_line_data import cache_pkg::*; (
  input  logic clk,
  input  line_ix_t line_ix,
  input  word_ix_t word_ix,
  input  byte_en_t byte_en,
  input  cache_word_t wdata,
  // merge enabled bytes of wdata into the addressed word
  input  logic write_word,
  // beat slot for both fill and drain
  input  beat_ix_t beat_ix,
  input  ram_word_t fill_beat,
  input  logic fill_en,
  output cache_word_t word_out,
  output ram_word_t drain_beat
);

  localparam int LINES = 2 ** `CACHE_LINE_IX_W;
  localparam int WORDS = 2 ** `CACHE_WORD_IX_W;
  localparam int WPB = `CACHE_WORDS_PER_BEAT;
  localparam int WORD_W = $bits(cache_word_t);
  localparam int BYTES = $bits(byte_en_t);

  cache_word_t lines [LINES][WORDS];

  always_ff @(posedge clk) begin
    // byte merge from a hit or the post-fill merge
    if (write_word) begin
      for (int b = 0; b < BYTES; b++) begin
        if (byte_en[b]) begin
          lines[line_ix][word_ix][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
    // one ram beat covers WPB consecutive words
    if (fill_en) begin
      for (int w = 0; w < WPB; w++) begin
        lines[line_ix][word_ix_t'(int'(beat_ix) * WPB + w)] <= fill_beat[w*WORD_W +: WORD_W];
      end
    end
  end

  // addressed word, read asynchronously so a hit answers in the lookup cycle
  assign word_out = lines[line_ix][word_ix];

  // beat presented to the ram during write-back
  always_comb begin
    drain_beat = '0;
    for (int w = 0; w < WPB; w++) begin
      drain_beat[w*WORD_W +: WORD_W] = lines[line_ix][word_ix_t'(int'(beat_ix) * WPB + w)];
    end
  end

endmodule

// File: verilog/cache_tags.sv
/*
  valid, dirty and tag per line; lookup is combinational on the registered
  request, updates land at the next clock edge
*/
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_tags import cache_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  cache_addr_u lookup_addr,
  // install the request tag as valid and clean
  input  logic set_line,
  // mark the indexed line modified
  input  logic set_dirty,
  output logic hit,
  output logic dirty,
  output tag_t victim_tag
);

  localparam int LINES = 2 ** `CACHE_LINE_IX_W;

  logic [LINES-1:0] valid_bits;
  logic [LINES-1:0] dirty_bits;
  tag_t tags [LINES];

  line_ix_t ix;

  assign ix = lookup_addr.f.line_ix;

  // hit needs a valid line with a matching tag
  assign hit = valid_bits[ix] && (tags[ix] == lookup_addr.f.tag);

  // dirty is only ever set on a valid line
  assign dirty = dirty_bits[ix];

  // tag of whatever currently sits in the indexed line, for write-back
  assign victim_tag = tags[ix];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (set_line) begin
        valid_bits[ix] <= 1'b1;
        dirty_bits[ix] <= 1'b0;
      end
      // a write in the same cycle as an install leaves the line dirty
      if (set_dirty) begin
        dirty_bits[ix] <= 1'b1;
      end
    end
  end

  // tag storage, meaningless until valid is set
  always_ff @(posedge clk) begin
    if (set_line) begin
      tags[ix] <= lookup_addr.f.tag;
    end
  end

endmodule

// File: verilog/cache_pkg.sv
/*
  shared cache types; field layout of the request address is
  tag | line index | word index | byte offset, msb first
*/
`include "cache_config.svh"

package cache_pkg;

  typedef logic [`CACHE_TAG_W-1:0] tag_t;
  typedef logic [`CACHE_LINE_IX_W-1:0] line_ix_t;
  typedef logic [`CACHE_WORD_IX_W-1:0] word_ix_t;

  // request address split into its lookup fields
  typedef struct packed {
    tag_t tag;
    line_ix_t line_ix;
    word_ix_t word_ix;
    logic [`CACHE_BYTE_OFS_W-1:0] byte_ofs;
  } cache_addr_fields_t;

  // same word seen whole (ram address math) or by field (lookup)
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] raw;
    cache_addr_fields_t f;
  } cache_addr_u;

  typedef logic [`CACHE_WORD_W-1:0] cache_word_t;

  // one enable per byte of a cached word, all zero means read
  typedef logic [`CACHE_WORD_W/8-1:0] byte_en_t;

  typedef logic [`CACHE_RAM_WORD_W-1:0] ram_word_t;
  typedef logic [`CACHE_RAM_ADDR_W-1:0] ram_addr_t;

  // beat position inside a burst
  typedef logic [$clog2(`CACHE_BURST_LEN)-1:0] beat_ix_t;

endpackage

// File: include/cache_config.svh
/*
  cache geometry and ram burst shape; one burst must carry exactly one line
  (burst_len * ram_word_w == 2**word_ix_w * word_w)
*/
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address width
`define CACHE_ADDR_W 32

// cached word width, multiple of 8
`define CACHE_WORD_W 32

// low address bits that are zero for word aligned requests
`define CACHE_BYTE_OFS_W 2

// 8 words per line
`define CACHE_WORD_IX_W 3

// 2 lines
`define CACHE_LINE_IX_W 1

// what is left of the address above line index
`define CACHE_TAG_W 26

// ram beat width
`define CACHE_RAM_WORD_W 64

// 256 beats of ram, so 2 KB of distinct bytes
`define CACHE_RAM_ADDR_W 8

// beats per burst
`define CACHE_BURST_LEN 4

// cache words packed into one ram beat, word 0 in the low bits
`define CACHE_WORDS_PER_BEAT 2

`endif
